// ==== rtl/u2_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths, settings addresses and control-pin payload
// types for the mainboard control plane
////////////////////////////////////////////////////////////

package u2_ctrl_pkg;

   // Bus and settings widths
   localparam int AXIL_ADDR_W = 10;
   localparam int DATA_W      = 32;
   localparam int SET_ADDR_W  = 8;

   ////////////////////////////////////////////////////////////
   // Settings bus address map
   localparam logic [SET_ADDR_W-1:0] SR_CLOCK      = 8'd0;
   localparam logic [SET_ADDR_W-1:0] SR_SERDES     = 8'd1;
   localparam logic [SET_ADDR_W-1:0] SR_ADC        = 8'd2;
   localparam logic [SET_ADDR_W-1:0] SR_LED        = 8'd3;
   localparam logic [SET_ADDR_W-1:0] SR_PHY        = 8'd4;
   localparam logic [SET_ADDR_W-1:0] SR_LED_SRC    = 8'd8;
   // Time words, secs is write to arm and read for current value
   localparam logic [SET_ADDR_W-1:0] SR_TIME_SECS  = 8'd192;
   localparam logic [SET_ADDR_W-1:0] SR_TIME_TICKS = 8'd193;

   // 100 MHz sample clock
   localparam int unsigned TICKS_PER_SEC_DEFAULT = 100_000_000;

   ////////////////////////////////////////////////////////////
   // Control-pin payloads, MSB first
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_t;

   typedef logic [7:0] led_t;

   // High holds the PHY in reset
   typedef logic phy_t;

endpackage

// ==== rtl/setting_reg.sv ====
////////////////////////////////////////////////////////////
// Single settings register, loads its payload on a strobe
// at its own address
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module setting_reg #(
   parameter type                                   payload_t = logic [31:0],
   parameter logic [u2_ctrl_pkg::SET_ADDR_W-1:0]    ADDR      = '0
) (
   input  logic                               dsp_clk,
   input  logic                               wb_rst,
   input  logic                               set_stb_i,
   input  logic [u2_ctrl_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [u2_ctrl_pkg::DATA_W-1:0]     set_data_i,
   output payload_t                           value_o
);

   localparam int PAYLOAD_W = $bits(payload_t);

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         value_o <= '0;
      end else if (set_stb_i && (set_addr_i == ADDR)) begin
         // Low bits of the word only
         value_o <= payload_t'(set_data_i[PAYLOAD_W-1:0]);
      end
   end

endmodule

// ==== rtl/axil_settings_bus.sv ====
////////////////////////////////////////////////////////////
// AXI4-Lite slave to settings bus bridge
// Writes become one-cycle settings strobes, reads fetch a readback word
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module axil_settings_bus (
   input  logic                                dsp_clk,
   input  logic                                wb_rst,
   // Write address channel
   input  logic                                awvalid_i,
   output logic                                awready_o,
   input  logic [u2_ctrl_pkg::AXIL_ADDR_W-1:0] awaddr_i,
   // Write data channel
   input  logic                                wvalid_i,
   output logic                                wready_o,
   input  logic [u2_ctrl_pkg::DATA_W-1:0]      wdata_i,
   // Write response channel, always OKAY
   output logic                                bvalid_o,
   input  logic                                bready_i,
   // Read address channel
   input  logic                                arvalid_i,
   output logic                                arready_o,
   input  logic [u2_ctrl_pkg::AXIL_ADDR_W-1:0] araddr_i,
   // Read data channel, always OKAY
   output logic                                rvalid_o,
   input  logic                                rready_i,
   output logic [u2_ctrl_pkg::DATA_W-1:0]      rdata_o,
   // Settings bus
   output logic                                set_stb_o,
   output logic [u2_ctrl_pkg::SET_ADDR_W-1:0]  set_addr_o,
   output logic [u2_ctrl_pkg::DATA_W-1:0]      set_data_o,
   // Readback port
   output logic [u2_ctrl_pkg::SET_ADDR_W-1:0]  rb_addr_o,
   input  logic [u2_ctrl_pkg::DATA_W-1:0]      rb_data_i
);

   typedef enum logic [1:0] {
      IDLE,
      WRITE_RESP,
      READ_FETCH,
      READ_RESP
   } state_t;

   state_t state;
   logic   wr_go;
   logic   rd_go;

   ////////////////////////////////////////////////////////////
   // Handshake decode
   // Full write offer needs both address and data
   assign wr_go = (state == IDLE) && awvalid_i && wvalid_i;
   // Write wins a tie with a read
   assign rd_go = (state == IDLE) && arvalid_i && !(awvalid_i && wvalid_i);

   assign awready_o = wr_go;
   assign wready_o  = wr_go;
   assign arready_o = rd_go;

   // Responses straight from state
   assign bvalid_o = (state == WRITE_RESP);
   assign rvalid_o = (state == READ_RESP);

   ////////////////////////////////////////////////////////////
   // FSM and settings strobe
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         state     <= IDLE;
         set_stb_o <= 1'b0;
      end else begin
         // One strobe per accepted write
         set_stb_o <= wr_go;
         case (state)
            IDLE: begin
               if (wr_go) begin
                  state <= WRITE_RESP;
               end else if (rd_go) begin
                  state <= READ_FETCH;
               end
            end
            WRITE_RESP: begin
               if (bready_i) begin
                  state <= IDLE;
               end
            end
            // Readback mux settles during this cycle
            READ_FETCH: begin
               state <= READ_RESP;
            end
            READ_RESP: begin
               if (rready_i) begin
                  state <= IDLE;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Address and data capture
   always_ff @(posedge dsp_clk) begin
      // Word address from byte address
      if (wr_go) begin
         set_addr_o <= awaddr_i[u2_ctrl_pkg::AXIL_ADDR_W-1:2];
         set_data_o <= wdata_i;
      end
      if (rd_go) begin
         rb_addr_o <= araddr_i[u2_ctrl_pkg::AXIL_ADDR_W-1:2];
      end
      // Held through READ_RESP until rready
      if (state == READ_FETCH) begin
         rdata_o <= rb_data_i;
      end
   end

endmodule

// ==== rtl/ctrl_regs.sv ====
////////////////////////////////////////////////////////////
// Control settings bank, LED source mux and readback select
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module ctrl_regs (
   input  logic                               dsp_clk,
   input  logic                               wb_rst,
   // Settings bus
   input  logic                               set_stb_i,
   input  logic [u2_ctrl_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [u2_ctrl_pkg::DATA_W-1:0]     set_data_i,
   // Readback
   input  logic [u2_ctrl_pkg::SET_ADDR_W-1:0] rb_addr_i,
   output logic [u2_ctrl_pkg::DATA_W-1:0]     rb_data_o,
   input  logic [u2_ctrl_pkg::DATA_W-1:0]     secs_i,
   input  logic [u2_ctrl_pkg::DATA_W-1:0]     ticks_i,
   // Hardware LED sources
   input  logic                               clk_status_i,
   input  logic                               serdes_link_up_i,
   // Control pins
   output u2_ctrl_pkg::led_t                  leds_o,
   output u2_ctrl_pkg::clock_t                clock_o,
   output u2_ctrl_pkg::serdes_t               serdes_o,
   output u2_ctrl_pkg::adc_t                  adc_o,
   output logic                               phy_resetn_o
);

   u2_ctrl_pkg::led_t led_sw;
   u2_ctrl_pkg::led_t led_src;
   u2_ctrl_pkg::led_t led_hw;
   u2_ctrl_pkg::phy_t phy_reset;

   ////////////////////////////////////////////////////////////
   // Settings registers
   setting_reg #(.payload_t(u2_ctrl_pkg::clock_t), .ADDR(u2_ctrl_pkg::SR_CLOCK)) sr_clock (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(clock_o));

   setting_reg #(.payload_t(u2_ctrl_pkg::serdes_t), .ADDR(u2_ctrl_pkg::SR_SERDES)) sr_serdes (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(serdes_o));

   setting_reg #(.payload_t(u2_ctrl_pkg::adc_t), .ADDR(u2_ctrl_pkg::SR_ADC)) sr_adc (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(adc_o));

   setting_reg #(.payload_t(u2_ctrl_pkg::led_t), .ADDR(u2_ctrl_pkg::SR_LED)) sr_led (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(led_sw));

   setting_reg #(.payload_t(u2_ctrl_pkg::led_t), .ADDR(u2_ctrl_pkg::SR_LED_SRC)) sr_led_src (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(led_src));

   setting_reg #(.payload_t(u2_ctrl_pkg::phy_t), .ADDR(u2_ctrl_pkg::SR_PHY)) sr_phy (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(phy_reset));

   ////////////////////////////////////////////////////////////
   // LEDs, source bit 1 picks hardware and 0 picks software
   assign led_hw = {6'b0, clk_status_i, serdes_link_up_i};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   // Pin is active low
   assign phy_resetn_o = ~phy_reset;

   ////////////////////////////////////////////////////////////
   // Readback select
   always_comb begin
      // Unmapped reads return zero
      rb_data_o = '0;
      case (rb_addr_i)
         u2_ctrl_pkg::SR_CLOCK:      rb_data_o[$bits(u2_ctrl_pkg::clock_t)-1:0] = clock_o;
         u2_ctrl_pkg::SR_SERDES:     rb_data_o[$bits(u2_ctrl_pkg::serdes_t)-1:0] = serdes_o;
         u2_ctrl_pkg::SR_ADC:        rb_data_o[$bits(u2_ctrl_pkg::adc_t)-1:0] = adc_o;
         u2_ctrl_pkg::SR_LED:        rb_data_o[$bits(u2_ctrl_pkg::led_t)-1:0] = led_sw;
         u2_ctrl_pkg::SR_LED_SRC:    rb_data_o[$bits(u2_ctrl_pkg::led_t)-1:0] = led_src;
         // Stored setting, not the inverted pin
         u2_ctrl_pkg::SR_PHY:        rb_data_o[0] = phy_reset;
         u2_ctrl_pkg::SR_TIME_SECS:  rb_data_o = secs_i;
         u2_ctrl_pkg::SR_TIME_TICKS: rb_data_o = ticks_i;
         default:                    rb_data_o = '0;
      endcase
   end

endmodule

// ==== rtl/vita_time.sv ====
////////////////////////////////////////////////////////////
// VITA time counter, seconds and ticks with PPS-armed load
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module vita_time #(
   parameter int unsigned TICKS_PER_SEC = u2_ctrl_pkg::TICKS_PER_SEC_DEFAULT
) (
   input  logic                               dsp_clk,
   input  logic                               wb_rst,
   input  logic                               set_stb_i,
   input  logic [u2_ctrl_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [u2_ctrl_pkg::DATA_W-1:0]     set_data_i,
   input  logic                               pps_i,
   output logic [u2_ctrl_pkg::DATA_W-1:0]     secs_o,
   output logic [u2_ctrl_pkg::DATA_W-1:0]     ticks_o
);

   localparam logic [u2_ctrl_pkg::DATA_W-1:0] LAST_TICK = u2_ctrl_pkg::DATA_W'(TICKS_PER_SEC - 1);

   logic                              pps_meta;
   logic                              pps_sync;
   logic                              pps_sync_d;
   logic                              pps_edge;
   logic                              load_armed;
   logic [u2_ctrl_pkg::DATA_W-1:0]    secs_load;
   logic                              secs_wr;

   assign secs_wr  = set_stb_i && (set_addr_i == u2_ctrl_pkg::SR_TIME_SECS);
   // Rising edge after the two-flop sync
   assign pps_edge = pps_sync && !pps_sync_d;

   ////////////////////////////////////////////////////////////
   // PPS synchronizer, async input
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         pps_meta   <= 1'b0;
         pps_sync   <= 1'b0;
         pps_sync_d <= 1'b0;
      end else begin
         pps_meta   <= pps_i;
         pps_sync   <= pps_meta;
         pps_sync_d <= pps_sync;
      end
   end

   // Armed seconds value
   always_ff @(posedge dsp_clk) begin
      if (secs_wr) begin
         secs_load <= set_data_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // Counter and load
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         secs_o     <= '0;
         ticks_o    <= '0;
         load_armed <= 1'b0;
      end else begin
         if (pps_edge && load_armed) begin
            // Jump to new epoch at PPS
            secs_o     <= secs_load;
            ticks_o    <= '0;
            load_armed <= 1'b0;
         end else if (ticks_o == LAST_TICK) begin
            ticks_o <= '0;
            secs_o  <= secs_o + 1'b1;
         end else begin
            ticks_o <= ticks_o + 1'b1;
         end
         // A fresh write re-arms even on a load cycle
         if (secs_wr) begin
            load_armed <= 1'b1;
         end
      end
   end

endmodule

// ==== rtl/u2_ctrl.sv ====
////////////////////////////////////////////////////////////
// Mainboard control plane top, AXI4-Lite settings access,
// control pins, LEDs and VITA time
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module u2_ctrl #(
   parameter int unsigned TICKS_PER_SEC = u2_ctrl_pkg::TICKS_PER_SEC_DEFAULT
) (
   input  logic                                dsp_clk,
   input  logic                                wb_rst,
   // AXI4-Lite slave
   input  logic                                awvalid_i,
   output logic                                awready_o,
   input  logic [u2_ctrl_pkg::AXIL_ADDR_W-1:0] awaddr_i,
   input  logic                                wvalid_i,
   output logic                                wready_o,
   input  logic [u2_ctrl_pkg::DATA_W-1:0]      wdata_i,
   output logic                                bvalid_o,
   input  logic                                bready_i,
   input  logic                                arvalid_i,
   output logic                                arready_o,
   input  logic [u2_ctrl_pkg::AXIL_ADDR_W-1:0] araddr_i,
   output logic                                rvalid_o,
   input  logic                                rready_i,
   output logic [u2_ctrl_pkg::DATA_W-1:0]      rdata_o,
   // Board inputs
   input  logic                                pps_i,
   input  logic                                clk_status_i,
   input  logic                                serdes_link_up_i,
   // Control pins
   output logic [7:0]                          leds_o,
   output logic                                clock_ready_o,
   output logic [1:0]                          clk_en_o,
   output logic [1:0]                          clk_sel_o,
   output logic                                ser_enable_o,
   output logic                                ser_prbsen_o,
   output logic                                ser_loopen_o,
   output logic                                ser_rx_en_o,
   output logic                                adc_oe_a_o,
   output logic                                adc_on_a_o,
   output logic                                adc_oe_b_o,
   output logic                                adc_on_b_o,
   output logic                                phy_resetn_o
);

   // Settings bus
   logic                               set_stb;
   logic [u2_ctrl_pkg::SET_ADDR_W-1:0] set_addr;
   logic [u2_ctrl_pkg::DATA_W-1:0]     set_data;
   // Readback path
   logic [u2_ctrl_pkg::SET_ADDR_W-1:0] rb_addr;
   logic [u2_ctrl_pkg::DATA_W-1:0]     rb_data;
   logic [u2_ctrl_pkg::DATA_W-1:0]     secs;
   logic [u2_ctrl_pkg::DATA_W-1:0]     ticks;
   // Pin groups
   u2_ctrl_pkg::clock_t                clock;
   u2_ctrl_pkg::serdes_t               serdes;
   u2_ctrl_pkg::adc_t                  adc;

   ////////////////////////////////////////////////////////////
   // Host bus
   axil_settings_bus u_bus (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .awvalid_i(awvalid_i), .awready_o(awready_o), .awaddr_i(awaddr_i),
      .wvalid_i(wvalid_i), .wready_o(wready_o), .wdata_i(wdata_i),
      .bvalid_o(bvalid_o), .bready_i(bready_i),
      .arvalid_i(arvalid_i), .arready_o(arready_o), .araddr_i(araddr_i),
      .rvalid_o(rvalid_o), .rready_i(rready_i), .rdata_o(rdata_o),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data),
      .rb_addr_o(rb_addr), .rb_data_i(rb_data));

   // Settings bank and readback
   ctrl_regs u_regs (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .rb_addr_i(rb_addr), .rb_data_o(rb_data), .secs_i(secs), .ticks_i(ticks),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .leds_o(leds_o), .clock_o(clock), .serdes_o(serdes), .adc_o(adc),
      .phy_resetn_o(phy_resetn_o));

   // Time base
   vita_time #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_time (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .secs_o(secs), .ticks_o(ticks));

   ////////////////////////////////////////////////////////////
   // Payloads out to pins
   assign clock_ready_o = clock.clock_ready;
   assign clk_en_o      = clock.clk_en;
   assign clk_sel_o     = clock.clk_sel;

   assign ser_enable_o  = serdes.enable;
   assign ser_prbsen_o  = serdes.prbsen;
   assign ser_loopen_o  = serdes.loopen;
   assign ser_rx_en_o   = serdes.rx_en;

   assign adc_oe_a_o    = adc.oe_a;
   assign adc_on_a_o    = adc.on_a;
   assign adc_oe_b_o    = adc.oe_b;
   assign adc_on_b_o    = adc.on_b;

endmodule

// ==== testbench/u2_ctrl_sva.sv ====
////////////////////////////////////////////////////////////
// Bus protocol and reset checks for the control plane top
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module u2_ctrl_sva (
   input logic                           dsp_clk,
   input logic                           wb_rst,
   input logic                           awready_o,
   input logic                           wready_o,
   input logic                           arready_o,
   input logic                           bvalid_o,
   input logic                           bready_i,
   input logic                           rvalid_o,
   input logic                           rready_i,
   input logic [u2_ctrl_pkg::DATA_W-1:0] rdata_o,
   input logic                           set_stb,
   input logic [7:0]                     leds_o,
   input logic [4:0]                     clock_pins,
   input logic [3:0]                     serdes_pins,
   input logic [3:0]                     adc_pins,
   input logic                           phy_resetn_o
);

   // Failures seen, read by the testbench at the end
   int unsigned fail_count = 0;

   ////////////////////////////////////////////////////////////
   // Bus idle and pins at reset values right after reset
   assert property (@(posedge dsp_clk) wb_rst |=>
      (!awready_o && !wready_o && !arready_o && !bvalid_o && !rvalid_o &&
       leds_o == 8'h00 && clock_pins == 5'h00 && serdes_pins == 4'h0 &&
       adc_pins == 4'h0 && phy_resetn_o))
   else begin
      $error("Outputs not quiet after reset");
      fail_count++;
   end

   // Write response held under back-pressure
   assert property (@(posedge dsp_clk) disable iff (wb_rst)
      (bvalid_o && !bready_i) |=> bvalid_o)
   else begin
      $error("bvalid dropped before bready");
      fail_count++;
   end

   // Read response and its data held under back-pressure
   assert property (@(posedge dsp_clk) disable iff (wb_rst)
      (rvalid_o && !rready_i) |=> (rvalid_o && $stable(rdata_o)))
   else begin
      $error("rvalid or rdata changed before rready");
      fail_count++;
   end

   // Address and data accepted together, strobe and response next cycle
   assert property (@(posedge dsp_clk) disable iff (wb_rst)
      (awready_o || wready_o) |=> ($past(awready_o && wready_o) && set_stb && bvalid_o))
   else begin
      $error("Write not accepted as one address and data pair with strobe and response");
      fail_count++;
   end

   // Nothing accepted while a response waits
   assert property (@(posedge dsp_clk) disable iff (wb_rst)
      (bvalid_o || rvalid_o) |-> !(awready_o || wready_o || arready_o))
   else begin
      $error("Address accepted with a response pending");
      fail_count++;
   end

endmodule

bind u2_ctrl u2_ctrl_sva u_sva (
   .dsp_clk(dsp_clk),
   .wb_rst(wb_rst),
   .awready_o(awready_o),
   .wready_o(wready_o),
   .arready_o(arready_o),
   .bvalid_o(bvalid_o),
   .bready_i(bready_i),
   .rvalid_o(rvalid_o),
   .rready_i(rready_i),
   .rdata_o(rdata_o),
   .set_stb(set_stb),
   .leds_o(leds_o),
   .clock_pins({clock_ready_o, clk_en_o, clk_sel_o}),
   .serdes_pins({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}),
   .adc_pins({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}),
   .phy_resetn_o(phy_resetn_o)
);

// ==== testbench/u2_ctrl_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the control plane top, AXI4-Lite stimulus
// with random back-pressure, pin, readback and time checks
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module u2_ctrl_tb;

   localparam int CLK_NS    = 20;
   localparam int RESET_CYC = 16;
   localparam int TPS       = 50;
   // Reset and six tests take about 750 cycles, 1000 leaves room for long stalls
   localparam int WATCHDOG_NS = 1000 * CLK_NS;

   logic        dsp_clk = 1'b0;
   logic        wb_rst;
   logic        awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
   logic [9:0]  awaddr_i, araddr_i;
   logic [31:0] wdata_i, rdata_o;
   logic        awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
   logic        pps_i, clk_status_i, serdes_link_up_i;
   logic [7:0]  leds_o;
   logic        clock_ready_o, ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic [1:0]  clk_en_o, clk_sel_o;
   logic        adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o, phy_resetn_o;

   integer      seed     = 2805;
   int          errors   = 0;
   int          mark     = 0;
   int          tests    = 0;
   int          hold_max = 3;
   // Rising edges so far, and where the last PPS rose and the last read captured
   int unsigned cycle    = 0;
   int unsigned pps_cycle;
   int unsigned rd_cycle;
   // Shadow copies of what the host wrote
   logic [31:0] sh_clock, sh_serdes, sh_adc, sh_led, sh_src, sh_phy;
   logic [31:0] rd;
   logic [31:0] secs_s;

   always #(CLK_NS / 2) dsp_clk = ~dsp_clk;

   always @(posedge dsp_clk) cycle <= cycle + 1;

   u2_ctrl #(.TICKS_PER_SEC(TPS)) u_dut (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .awvalid_i(awvalid_i), .awready_o(awready_o), .awaddr_i(awaddr_i),
      .wvalid_i(wvalid_i), .wready_o(wready_o), .wdata_i(wdata_i),
      .bvalid_o(bvalid_o), .bready_i(bready_i),
      .arvalid_i(arvalid_i), .arready_o(arready_o), .araddr_i(araddr_i),
      .rvalid_o(rvalid_o), .rready_i(rready_i), .rdata_o(rdata_o),
      .pps_i(pps_i), .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .leds_o(leds_o), .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o),
      .clk_sel_o(clk_sel_o), .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o), .adc_oe_b_o(adc_oe_b_o),
      .adc_on_b_o(adc_on_b_o), .phy_resetn_o(phy_resetn_o));

   function automatic int pick_hold();
      return int'($unsigned($random(seed)) % hold_max);
   endfunction

   // Source bit 1 takes the hardware bit, 0 the software bit
   function automatic logic [7:0] expected_leds(input logic [7:0] sw, input logic [7:0] src);
      logic [7:0] hw;
      logic [7:0] led;
      hw    = 8'h00;
      hw[0] = serdes_link_up_i;
      hw[1] = clk_status_i;
      for (int b = 0; b < 8; b++) begin
         led[b] = src[b] ? hw[b] : sw[b];
      end
      return led;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("Mismatch at %0t: %s expected 0x%08h actual 0x%08h",
                  $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_range(input string name, input logic [31:0] lo,
                              input logic [31:0] hi, input logic [31:0] actual);
      assert (actual >= lo && actual <= hi) else begin
         $display("Mismatch at %0t: %s expected 0x%08h to 0x%08h actual 0x%08h",
                  $time, name, lo, hi, actual);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // AXI4-Lite host, called on a falling edge
   task automatic axil_write(input logic [7:0] sa, input logic [31:0] data);
      int hold;
      hold      = pick_hold();
      awaddr_i  = {sa, 2'b00};
      wdata_i   = data;
      awvalid_i = 1'b1;
      wvalid_i  = 1'b1;
      // bvalid marks the transfer one edge back
      @(negedge dsp_clk);
      while (!bvalid_o) @(negedge dsp_clk);
      awvalid_i = 1'b0;
      wvalid_i  = 1'b0;
      repeat (hold) @(negedge dsp_clk);
      bready_i = 1'b1;
      @(negedge dsp_clk);
      bready_i = 1'b0;
   endtask

   task automatic axil_read(input logic [7:0] sa, output logic [31:0] data);
      int hold;
      hold      = pick_hold();
      araddr_i  = {sa, 2'b00};
      arvalid_i = 1'b1;
      @(negedge dsp_clk);
      // Slave busy or still ready means no transfer yet
      while (arready_o || bvalid_o || rvalid_o) @(negedge dsp_clk);
      arvalid_i = 1'b0;
      while (!rvalid_o) @(negedge dsp_clk);
      rd_cycle  = cycle;
      data      = rdata_o;
      repeat (hold) @(negedge dsp_clk);
      rready_i = 1'b1;
      @(negedge dsp_clk);
      rready_i = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Pins and readback against the shadow copies
   task automatic check_pins();
      check_value("clock pins", sh_clock & 32'h1f, 32'({clock_ready_o, clk_en_o, clk_sel_o}));
      check_value("serdes pins", sh_serdes & 32'hf,
                  32'({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}));
      check_value("adc pins", sh_adc & 32'hf,
                  32'({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}));
      check_value("phy_resetn_o", 32'(!sh_phy[0]), 32'(phy_resetn_o));
      check_value("leds_o", 32'(expected_leds(sh_led[7:0], sh_src[7:0])), 32'(leds_o));
   endtask

   task automatic check_readback();
      logic [31:0] data;
      axil_read(u2_ctrl_pkg::SR_CLOCK, data);
      check_value("SR_CLOCK readback", sh_clock & 32'h1f, data);
      axil_read(u2_ctrl_pkg::SR_SERDES, data);
      check_value("SR_SERDES readback", sh_serdes & 32'hf, data);
      axil_read(u2_ctrl_pkg::SR_ADC, data);
      check_value("SR_ADC readback", sh_adc & 32'hf, data);
      axil_read(u2_ctrl_pkg::SR_LED, data);
      check_value("SR_LED readback", sh_led & 32'hff, data);
      axil_read(u2_ctrl_pkg::SR_LED_SRC, data);
      check_value("SR_LED_SRC readback", sh_src & 32'hff, data);
      axil_read(u2_ctrl_pkg::SR_PHY, data);
      check_value("SR_PHY readback", sh_phy & 32'h1, data);
   endtask

   task automatic pulse_pps();
      pps_cycle = cycle;
      pps_i = 1'b1;
      repeat (4) @(negedge dsp_clk);
      pps_i = 1'b0;
      @(negedge dsp_clk);
   endtask

   task automatic end_test(input string name);
      $display("Test %s finished with %0d errors", name, errors - mark);
      mark = errors;
      tests++;
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   initial begin
      wb_rst    = 1'b1;
      awvalid_i = 1'b0;
      wvalid_i  = 1'b0;
      bready_i  = 1'b0;
      arvalid_i = 1'b0;
      rready_i  = 1'b0;
      awaddr_i  = '0;
      araddr_i  = '0;
      wdata_i   = '0;
      pps_i     = 1'b0;
      clk_status_i     = 1'b0;
      serdes_link_up_i = 1'b0;
      {sh_clock, sh_serdes, sh_adc, sh_led, sh_src, sh_phy} = '0;
      repeat (RESET_CYC) @(negedge dsp_clk);
      wb_rst = 1'b0;
      repeat (2) @(negedge dsp_clk);

      check_value("ready and valid outputs", 32'h0,
                  32'({awready_o, wready_o, arready_o, bvalid_o, rvalid_o}));
      check_pins();
      check_readback();
      end_test("reset state");

      for (int i = 0; i < 4; i++) begin
         sh_clock  = $random(seed);
         sh_serdes = $random(seed);
         sh_adc    = $random(seed);
         sh_phy    = $random(seed);
         axil_write(u2_ctrl_pkg::SR_CLOCK, sh_clock);
         axil_write(u2_ctrl_pkg::SR_SERDES, sh_serdes);
         axil_write(u2_ctrl_pkg::SR_ADC, sh_adc);
         axil_write(u2_ctrl_pkg::SR_PHY, sh_phy);
         check_pins();
         check_readback();
      end
      end_test("control pins");

      for (int i = 0; i < 4; i++) begin
         sh_led = $random(seed);
         sh_src = $random(seed);
         axil_write(u2_ctrl_pkg::SR_LED, sh_led);
         axil_write(u2_ctrl_pkg::SR_LED_SRC, sh_src);
         rd               = $random(seed);
         clk_status_i     = rd[1];
         serdes_link_up_i = rd[0];
         @(negedge dsp_clk);
         check_pins();
      end
      end_test("LED select");

      // Long bready and rready stalls
      hold_max = 12;
      for (int i = 0; i < 3; i++) begin
         sh_adc = $random(seed);
         axil_write(u2_ctrl_pkg::SR_ADC, sh_adc);
         check_readback();
         check_readback();
      end
      hold_max = 3;
      end_test("back-pressure");

      rd     = $random(seed);
      secs_s = {1'b0, rd[30:0]};
      axil_write(u2_ctrl_pkg::SR_TIME_SECS, secs_s);
      pulse_pps();
      axil_read(u2_ctrl_pkg::SR_TIME_SECS, rd);
      check_value("seconds after load", secs_s, rd);
      axil_read(u2_ctrl_pkg::SR_TIME_TICKS, rd);
      // Load lands 3 edges after the PPS rise, rdata is taken one edge before rvalid
      check_value("ticks after load", rd_cycle - pps_cycle - 32'd4, rd);
      repeat (150) @(negedge dsp_clk);
      axil_read(u2_ctrl_pkg::SR_TIME_SECS, rd);
      check_range("seconds after 150 cycles", secs_s + 32'd2, secs_s + 32'd4, rd);
      // Unarmed PPS must not reload
      pulse_pps();
      axil_read(u2_ctrl_pkg::SR_TIME_SECS, rd);
      check_range("seconds after unarmed PPS", secs_s + 32'd2, secs_s + 32'd4, rd);
      end_test("VITA time");

      axil_read(8'd100, rd);
      check_value("unmapped readback", 32'h0, rd);
      axil_write(8'd100, $random(seed));
      check_pins();
      check_readback();
      end_test("unmapped addresses");

      $display("%0d tests run, %0d check errors, %0d assertion failures",
               tests, errors, u_dut.u_sva.fail_count);
      if (errors == 0 && u_dut.u_sva.fail_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("Run timed out after %0d ns before the tests finished", WATCHDOG_NS);
      $display("** FAIL **");
      $finish;
   end

endmodule

// ==== u2_ctrl.f ====
rtl/u2_ctrl_pkg.sv
rtl/setting_reg.sv
rtl/axil_settings_bus.sv
rtl/ctrl_regs.sv
rtl/vita_time.sv
rtl/u2_ctrl.sv
testbench/u2_ctrl_sva.sv
testbench/u2_ctrl_tb.sv

// ==== Makefile ====
TOP = u2_ctrl_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f u2_ctrl.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -F -x '** PASS **' > /dev/null

clean:
	rm -rf obj_dir
